//--- common/cpu_pkg.sv
package cpu_pkg;

	localparam int XLEN = 32;
	localparam int NREGS = 16;
	localparam int SEL_W = 4;
	localparam logic [XLEN-1:0] RESET_PC = '0;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [3:0] reg_addr_t;
	typedef logic [SEL_W-1:0] sel_t;
	typedef logic [2:0] ccr_t; // ltu, lt, eq

	typedef enum logic [3:0] {
		T_INH = 4'h0,
		T_CMP = 4'h3,
		T_ALU = 4'h7,
		T_LDI = 4'h8,
		T_LOAD = 4'h9,
		T_STORE = 4'ha,
		T_BRANCH = 4'hb
	} insn_type_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SHL = 3'd5,
		ALU_SHR = 3'd6
	} alu_func_e;

	typedef enum logic [1:0] {
		MEM_WORD = 2'd0,
		MEM_HALF = 2'd1,
		MEM_BYTE = 2'd2
	} mem_size_e;

	typedef enum logic [1:0] {
		PC_HOLD = 2'd0,
		PC_NEXT = 2'd1,
		PC_REL = 2'd2
	} pc_sel_e;

	typedef enum logic [3:0] {
		S_RESET,
		S_FETCH,
		S_FETCH_WAIT,
		S_EVAL,
		S_ALU,
		S_ALU_EXEC,
		S_ALU_WB,
		S_LDI,
		S_CMP,
		S_BRANCH,
		S_LOAD,
		S_STORE,
		S_MEM_WAIT,
		S_LOAD_WB,
		S_HALT
	} ctrl_state_e;

	// register write-back sources
	localparam logic [1:0] RSRC_ALU = 2'd0;
	localparam logic [1:0] RSRC_IMM = 2'd1;
	localparam logic [1:0] RSRC_LOAD = 2'd2;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		sel_t sel;
		logic [XLEN-3:0] adr; // word address
		word_t dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		word_t dat;
	} wb_rsp_t;

	typedef struct packed {
		logic a_write;
		logic b_write;
		reg_addr_t rd_addr1;
		reg_addr_t rd_addr2;
		logic reg_write;
		logic [1:0] reg_src;
		alu_func_e alu_func;
		logic imm_sel;
		logic ccr_write;
		pc_sel_e pc_sel;
		logic mar_write;
		logic mdr_write;
	} dp_ctrl_t;

endpackage

//--- control/cpu_control.sv
module cpu_control import cpu_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input word_t ir,
	input ccr_t ccr,
	output dp_ctrl_t dp_ctrl,
	output logic fetch_start,
	input logic fetch_done,
	output logic mem_start,
	input logic mem_done,
	output logic mem_we,
	output mem_size_e mem_size,
	output logic halted
);

	ctrl_state_e state;
	ctrl_state_e state_next;
	insn_type_e ir_type;
	logic [3:0] ir_op;
	reg_addr_t ir_rb;
	reg_addr_t ir_rc;
	logic ccr_ltu;
	logic ccr_lt;
	logic ccr_eq;
	logic take_branch;

	assign ir_type = insn_type_e'(ir[31:28]);
	assign ir_op = ir[27:24];
	assign ir_rb = ir[19:16];
	assign ir_rc = ir[15:12];
	assign {ccr_ltu, ccr_lt, ccr_eq} = ccr;

	assign fetch_start = (state == S_FETCH);
	assign mem_start = (state == S_LOAD) || (state == S_STORE);
	assign mem_we = (ir_type == T_STORE);
	assign mem_size = mem_size_e'(ir_op[1:0]);
	assign halted = (state == S_HALT);

	always_comb
	begin
		case (ir_op)
			4'h0: take_branch = 1'b1; // bra
			4'h1: take_branch = ccr_eq;
			4'h2: take_branch = !ccr_eq;
			4'h3: take_branch = !(ccr_ltu || ccr_eq); // bgtu
			4'h4: take_branch = !(ccr_lt || ccr_eq);
			4'h5: take_branch = !ccr_lt;
			4'h6: take_branch = ccr_lt || ccr_eq;
			4'h7: take_branch = ccr_lt;
			4'h8: take_branch = !ccr_ltu; // bgeu
			4'h9: take_branch = ccr_ltu;
			4'ha: take_branch = ccr_ltu || ccr_eq;
			default: take_branch = 1'b0;
		endcase
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			state <= S_RESET;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		dp_ctrl = '{a_write: 1'b0, b_write: 1'b0, rd_addr1: ir[23:20], rd_addr2: ir_rb,
			reg_write: 1'b0, reg_src: RSRC_ALU, alu_func: ALU_ADD, imm_sel: 1'b0,
			ccr_write: 1'b0, pc_sel: PC_HOLD, mar_write: 1'b0, mdr_write: 1'b0};
		case (state)
			S_RESET: state_next = S_FETCH;
			S_FETCH: state_next = S_FETCH_WAIT;
			S_FETCH_WAIT:
			begin
				if (fetch_done)
				begin
					dp_ctrl.pc_sel = PC_NEXT;
					state_next = S_EVAL;
				end
			end
			S_EVAL:
			begin
				dp_ctrl.a_write = 1'b1; // A <= ra
				dp_ctrl.b_write = 1'b1; // B <= rb
				case (ir_type)
					T_INH: state_next = (ir_op == 4'h0) ? S_FETCH : S_HALT; // nop, else halt
					T_CMP: state_next = (ir_op == 4'h0) ? S_CMP : S_HALT;
					T_ALU: state_next = (ir_op[2:0] != 3'd7) ? S_ALU : S_HALT;
					T_LDI: state_next = S_LDI;
					T_LOAD: state_next = (ir_op < 4'h3) ? S_LOAD : S_HALT;
					T_STORE: state_next = (ir_op < 4'h3) ? S_STORE : S_HALT;
					T_BRANCH: state_next = (ir_op <= 4'ha) ? S_BRANCH : S_HALT;
					default: state_next = S_HALT;
				endcase
			end
			S_ALU:
			begin
				dp_ctrl.rd_addr1 = ir_rb;
				dp_ctrl.rd_addr2 = ir_rc;
				dp_ctrl.a_write = 1'b1;
				dp_ctrl.b_write = 1'b1;
				state_next = S_ALU_EXEC;
			end
			S_ALU_EXEC:
			begin
				dp_ctrl.alu_func = alu_func_e'(ir_op[2:0]);
				dp_ctrl.imm_sel = ir_op[3];
				state_next = S_ALU_WB;
			end
			S_ALU_WB:
			begin
				dp_ctrl.reg_write = 1'b1;
				state_next = S_FETCH;
			end
			S_LDI:
			begin
				dp_ctrl.reg_write = 1'b1;
				dp_ctrl.reg_src = RSRC_IMM;
				state_next = S_FETCH;
			end
			S_CMP:
			begin
				dp_ctrl.ccr_write = 1'b1;
				state_next = S_FETCH;
			end
			S_BRANCH:
			begin
				dp_ctrl.pc_sel = take_branch ? PC_REL : PC_HOLD;
				state_next = S_FETCH;
			end
			S_LOAD, S_STORE:
			begin
				dp_ctrl.imm_sel = 1'b1; // rb plus offset
				dp_ctrl.mar_write = 1'b1;
				dp_ctrl.mdr_write = (state == S_STORE);
				state_next = S_MEM_WAIT;
			end
			S_MEM_WAIT:
			begin
				if (mem_done)
					state_next = mem_we ? S_FETCH : S_LOAD_WB;
			end
			S_LOAD_WB:
			begin
				dp_ctrl.reg_write = 1'b1;
				dp_ctrl.reg_src = RSRC_LOAD;
				state_next = S_FETCH;
			end
			default: state_next = S_HALT;
		endcase
	end

	assert property (@(posedge clk_i) disable iff (rst_i) !$isunknown(state));
	assert property (@(posedge clk_i) disable iff (rst_i)
		mem_done |-> (state == S_MEM_WAIT));
	assert property (@(posedge clk_i) disable iff (rst_i)
		fetch_done |-> (state == S_FETCH_WAIT));

endmodule

//--- datapath/cpu_datapath.sv
module cpu_datapath import cpu_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input dp_ctrl_t dp_ctrl,
	input word_t ir,
	input word_t load_data,
	output word_t pc,
	output word_t mar,
	output word_t mdr,
	output ccr_t ccr
);

	word_t regs [NREGS];
	word_t a;
	word_t b;
	word_t simm;
	word_t uimm;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	word_t alu_q;
	word_t wb_data;
	logic [XLEN:0] diff;
	reg_addr_t wr_addr;

	assign simm = {{16{ir[15]}}, ir[15:0]};
	assign uimm = {16'h0000, ir[15:0]};
	assign wr_addr = ir[23:20];

	assign alu_a = dp_ctrl.mar_write ? b : a; // address states use rb as base
	assign alu_b = dp_ctrl.imm_sel ? simm : b;

	always_comb
	begin
		case (dp_ctrl.alu_func)
			ALU_ADD: alu_result = alu_a + alu_b;
			ALU_SUB: alu_result = alu_a - alu_b;
			ALU_AND: alu_result = alu_a & alu_b;
			ALU_OR: alu_result = alu_a | alu_b;
			ALU_XOR: alu_result = alu_a ^ alu_b;
			ALU_SHL: alu_result = alu_a << alu_b[4:0];
			ALU_SHR: alu_result = alu_a >> alu_b[4:0]; // logical
			default: alu_result = alu_a;
		endcase
	end

	always_comb
	begin
		case (dp_ctrl.reg_src)
			RSRC_IMM: wb_data = uimm;
			RSRC_LOAD: wb_data = load_data;
			default: wb_data = alu_q;
		endcase
	end

	assign diff = {1'b0, a} - {1'b0, b};

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
			pc <= RESET_PC;
			ccr <= '0;
		end
		else
		begin
			if (dp_ctrl.reg_write)
				regs[wr_addr] <= wb_data;
			case (dp_ctrl.pc_sel)
				PC_NEXT: pc <= pc + 32'd4;
				PC_REL: pc <= pc + {simm[XLEN-3:0], 2'b00};
				default: pc <= pc;
			endcase
			if (dp_ctrl.ccr_write)
				ccr <= {diff[XLEN], (a[XLEN-1] ^ b[XLEN-1]) ? a[XLEN-1] : diff[XLEN-1],
					diff[XLEN-1:0] == '0};
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (dp_ctrl.a_write)
			a <= regs[dp_ctrl.rd_addr1];
		if (dp_ctrl.b_write)
			b <= regs[dp_ctrl.rd_addr2];
		alu_q <= alu_result;
		if (dp_ctrl.mar_write)
			mar <= alu_result;
		if (dp_ctrl.mdr_write)
			mdr <= a; // ra for stores
	end

endmodule

//--- verilog/fetch_port.sv
module fetch_port import cpu_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input logic fetch_start,
	input word_t pc,
	output wb_req_t req,
	input logic ack,
	input word_t rdata,
	output logic fetch_done,
	output word_t ir
);

	logic busy;

	assign fetch_done = busy && ack;
	assign req = '{cyc: busy, stb: busy, we: 1'b0, sel: '1, adr: pc[XLEN-1:2], dat: '0};

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			busy <= 1'b0;
		else if (fetch_start)
			busy <= 1'b1;
		else if (fetch_done)
			busy <= 1'b0;
	end

	always_ff @(posedge clk_i)
	begin
		if (fetch_done)
			ir <= rdata;
	end

	// pc must not move under an open read
	assert property (@(posedge clk_i) disable iff (rst_i)
		(req.stb && !ack) |=> (req.stb && req.cyc && $stable(req.adr)));

endmodule

//--- verilog/data_port.sv
module data_port import cpu_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input logic mem_start,
	input logic mem_we,
	input mem_size_e mem_size,
	input word_t addr,
	input word_t wdata,
	output wb_req_t req,
	input logic ack,
	input word_t rdata,
	output logic mem_done,
	output word_t load_data
);

	logic busy;
	sel_t sel;
	word_t wdata_lanes;
	word_t extracted;
	logic [1:0] lane;

	assign lane = 2'd3 - addr[1:0]; // byte 0 sits in the top lane

	always_comb
	begin
		case (mem_size)
			MEM_HALF:
			begin
				sel = addr[1] ? 4'b0011 : 4'b1100;
				wdata_lanes = {2{wdata[15:0]}};
				extracted = {16'h0000, addr[1] ? rdata[15:0] : rdata[31:16]};
			end
			MEM_BYTE:
			begin
				sel = 4'b1000 >> addr[1:0];
				wdata_lanes = {4{wdata[7:0]}};
				extracted = {24'h000000, rdata[{lane, 3'b000} +: 8]};
			end
			default:
			begin
				sel = '1;
				wdata_lanes = wdata;
				extracted = rdata;
			end
		endcase
	end

	assign mem_done = busy && ack;
	assign req = '{cyc: busy, stb: busy, we: mem_we, sel: sel, adr: addr[XLEN-1:2],
		dat: wdata_lanes};

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			busy <= 1'b0;
		else if (mem_start)
			busy <= 1'b1;
		else if (mem_done)
			busy <= 1'b0;
	end

	always_ff @(posedge clk_i)
	begin
		if (mem_done && !mem_we)
			load_data <= extracted;
	end

	// request frozen until ack
	assert property (@(posedge clk_i) disable iff (rst_i)
		(req.cyc && !ack) |=> (req.cyc && $stable(req)));

endmodule

//--- verilog/bus_arbiter.sv
module bus_arbiter import cpu_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input wb_req_t fetch_req,
	input wb_req_t data_req,
	output logic fetch_ack,
	output logic data_ack,
	output wb_req_t bus_req,
	input logic bus_ack
);

	logic owner_valid;
	logic owner_data;
	logic active;
	logic grant_data;

	// owner keeps the bus until it drops cyc
	assign active = owner_valid && (owner_data ? data_req.cyc : fetch_req.cyc);
	assign grant_data = active ? owner_data : data_req.cyc; // data first when idle

	assign bus_req = grant_data ? data_req : fetch_req;
	assign data_ack = bus_ack && grant_data && data_req.cyc;
	assign fetch_ack = bus_ack && !grant_data && fetch_req.cyc;

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			owner_valid <= 1'b0;
			owner_data <= 1'b0;
		end
		else
		begin
			owner_valid <= bus_req.cyc;
			owner_data <= grant_data;
		end
	end

	// grant stays put for an open cycle
	assert property (@(posedge clk_i) disable iff (rst_i)
		(bus_req.cyc && !bus_ack) |=> (bus_req.cyc && $stable(grant_data)));

endmodule

//--- verilog/cpu_top.sv
module cpu_top import cpu_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	output wb_req_t bus_req,
	input wb_rsp_t bus_rsp,
	output logic halted
);

	word_t ir;
	ccr_t ccr;
	dp_ctrl_t dp_ctrl;
	logic fetch_start;
	logic fetch_done;
	logic mem_start;
	logic mem_done;
	logic mem_we;
	mem_size_e mem_size;
	word_t pc;
	word_t mar;
	word_t mdr;
	word_t load_data;
	wb_req_t fetch_req;
	wb_req_t data_req;
	logic fetch_ack;
	logic data_ack;

	cpu_control control_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.ir(ir),
		.ccr(ccr),
		.dp_ctrl(dp_ctrl),
		.fetch_start(fetch_start),
		.fetch_done(fetch_done),
		.mem_start(mem_start),
		.mem_done(mem_done),
		.mem_we(mem_we),
		.mem_size(mem_size),
		.halted(halted)
	);

	cpu_datapath datapath_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.dp_ctrl(dp_ctrl),
		.ir(ir),
		.load_data(load_data),
		.pc(pc),
		.mar(mar),
		.mdr(mdr),
		.ccr(ccr)
	);

	fetch_port fetch_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.fetch_start(fetch_start),
		.pc(pc),
		.req(fetch_req),
		.ack(fetch_ack),
		.rdata(bus_rsp.dat),
		.fetch_done(fetch_done),
		.ir(ir)
	);

	data_port data_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.mem_start(mem_start),
		.mem_we(mem_we),
		.mem_size(mem_size),
		.addr(mar),
		.wdata(mdr),
		.req(data_req),
		.ack(data_ack),
		.rdata(bus_rsp.dat),
		.mem_done(mem_done),
		.load_data(load_data)
	);

	bus_arbiter arbiter_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.fetch_req(fetch_req),
		.data_req(data_req),
		.fetch_ack(fetch_ack),
		.data_ack(data_ack),
		.bus_req(bus_req),
		.bus_ack(bus_rsp.ack)
	);

endmodule

//--- verif/wb_mem.sv
module wb_mem import cpu_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	input word_t init_image [1024],
	input wb_req_t req,
	output wb_rsp_t rsp,
	output logic wr_valid,
	output wb_req_t wr_req
);

	localparam int DEPTH = 1024;

	word_t mem [DEPTH];
	logic pending;
	int wait_left;
	logic [9:0] idx;

	assign idx = req.adr[9:0]; // wraps at the memory size

	function automatic word_t merge_lanes(input word_t old, input word_t dat, input sel_t sel);
		word_t merged;
		merged = old;
		for (int l = 0; l < SEL_W; l++)
		begin
			if (sel[l])
				merged[8*l +: 8] = dat[8*l +: 8];
		end
		return merged;
	endfunction

	always @(negedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= init_image[i];
			rsp <= '0;
			wr_valid <= 1'b0;
			wr_req <= '0;
			pending = 1'b0;
			wait_left = 0;
		end
		else
		begin
			wr_valid <= 1'b0;
			if (rsp.ack)
				rsp.ack <= 1'b0; // cycle closed on the last rising edge
			else if (req.cyc && req.stb)
			begin
				if (!pending)
				begin
					pending = 1'b1;
					wait_left = int'($urandom % 4); // 0 to 3 wait states
				end
				if (wait_left == 0)
				begin
					pending = 1'b0;
					rsp.ack <= 1'b1;
					rsp.dat <= mem[idx];
					if (req.we)
					begin
						mem[idx] <= merge_lanes(mem[idx], req.dat, req.sel);
						wr_valid <= 1'b1;
						wr_req <= req;
					end
				end
				else
					wait_left--;
			end
		end
	end

endmodule

//--- verif/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

	localparam int N_INSNS = 200;
	localparam int DUMP_START = N_INSNS - 16; // r0..r14 stored, then halt
	localparam int MEM_WORDS = 1024;
	localparam logic [15:0] DATA_BASE = 16'h0800;
	localparam int DATA_WORD = 512;
	localparam int DATA_WORDS = 64;
	localparam int TIMEOUT_CYCLES = N_INSNS * 20 + 100;
	localparam int HOLD_CYCLES = 20;
	localparam int MODEL_STEPS = 1000;
	localparam logic [31:0] SEED = 32'ha033;

	logic clk_i;
	logic rst_i;
	wb_req_t bus_req;
	wb_rsp_t bus_rsp;
	logic halted;
	logic wr_valid;
	wb_req_t wr_req;

	word_t image [MEM_WORDS];
	word_t model_mem [MEM_WORDS];
	wb_req_t exp_stores [$];
	int model_stores;
	int dut_stores;
	logic model_halted;
	int mismatch_errors;
	int other_errors;
	int cycles;
	logic dropped;

	cpu_top dut_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.halted(halted)
	);

	wb_mem mem_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.init_image(image),
		.req(bus_req),
		.rsp(bus_rsp),
		.wr_valid(wr_valid),
		.wr_req(wr_req)
	);

	function automatic word_t encode(input logic [3:0] kind, input logic [3:0] op,
		input reg_addr_t ra, input reg_addr_t rb, input logic [15:0] imm);
		return {kind, op, ra, rb, imm};
	endfunction

	function automatic logic [15:0] data_offset(input logic [1:0] size);
		logic [15:0] off;
		off = 16'($urandom % 256);
		if (size == MEM_WORD)
			off[1:0] = 2'b00;
		else if (size == MEM_HALF)
			off[0] = 1'b0;
		return off;
	endfunction

	// big-endian lanes, byte offset 0 is bits 31:24
	function automatic sel_t lane_sel(input logic [1:0] size, input logic [1:0] lo);
		sel_t sel;
		case (size)
			MEM_HALF: sel = lo[1] ? 4'b0011 : 4'b1100;
			MEM_BYTE: sel = 4'b0001 << (2'd3 - lo);
			default: sel = 4'b1111;
		endcase
		return sel;
	endfunction

	function automatic word_t lane_mask(input sel_t sel);
		word_t mask;
		for (int l = 0; l < SEL_W; l++)
			mask[8*l +: 8] = {8{sel[l]}};
		return mask;
	endfunction

	function automatic logic branch_taken(input logic [3:0] cond, input logic [2:0] cc);
		logic ltu;
		logic lt;
		logic eq;
		logic taken;
		{ltu, lt, eq} = cc;
		case (cond)
			4'h0: taken = 1'b1;
			4'h1: taken = eq;
			4'h2: taken = !eq;
			4'h3: taken = !ltu && !eq; // unsigned greater
			4'h4: taken = !lt && !eq;
			4'h5: taken = !lt;
			4'h6: taken = lt || eq;
			4'h7: taken = lt;
			4'h8: taken = !ltu;
			4'h9: taken = ltu;
			4'ha: taken = ltu || eq;
			default: taken = 1'b0;
		endcase
		return taken;
	endfunction

	task automatic build_program();
		int kind;
		int skip;
		int max_skip;
		logic [1:0] size;
		reg_addr_t ra;
		logic [15:0] imm;
		word_t w;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			w = i;
			image[i] = {16'ha5c3 ^ w[15:0], w[15:0]};
		end
		for (int i = 0; i < DATA_WORDS; i++)
			image[DATA_WORD + i] = $urandom;
		image[0] = encode(T_LDI, 4'h0, 4'hf, 4'h0, DATA_BASE);
		for (int i = 1; i < DUMP_START; i++)
		begin
			kind = int'($urandom % 9);
			ra = 4'($urandom % 15); // r15 keeps the data base
			size = 2'($urandom % 3);
			imm = 16'($urandom);
			case (kind)
				0, 1: image[i] = encode(T_ALU, 4'($urandom % 7), ra, 4'($urandom), imm);
				2: image[i] = encode(T_ALU, 4'(8 + $urandom % 7), ra, 4'($urandom), imm);
				3: image[i] = encode(T_LDI, 4'h0, ra, 4'h0, imm);
				4: image[i] = encode(T_CMP, 4'h0, 4'($urandom), 4'($urandom), imm);
				5:
				begin
					skip = int'($urandom % 4);
					max_skip = DUMP_START - 1 - i;
					if (skip > max_skip)
						skip = max_skip;
					image[i] = encode(T_BRANCH, 4'($urandom % 11), 4'h0, 4'h0, 16'(skip));
				end
				6: image[i] = encode(T_LOAD, {2'b00, size}, ra, 4'hf, data_offset(size));
				7: image[i] = encode(T_STORE, {2'b00, size}, 4'($urandom), 4'hf,
					data_offset(size));
				default: image[i] = encode(T_INH, 4'h0, 4'h0, 4'h0, 16'h0000); // nop
			endcase
		end
		for (int j = 0; j < 15; j++)
			image[DUMP_START + j] = encode(T_STORE, 4'h0, 4'(j), 4'hf, 16'(256 + 4 * j));
		image[N_INSNS - 1] = encode(T_INH, 4'h1, 4'h0, 4'h0, 16'h0000); // halt
	endtask

	task automatic run_model();
		word_t r [NREGS];
		word_t pc;
		word_t ir;
		word_t a;
		word_t b;
		word_t simm;
		word_t addr;
		word_t w;
		word_t res;
		word_t mask;
		logic [2:0] cc;
		logic [3:0] op;
		int shift;
		int steps;
		wb_req_t st;
		for (int i = 0; i < NREGS; i++)
			r[i] = '0;
		pc = RESET_PC;
		cc = '0;
		steps = 0;
		model_halted = 1'b0;
		model_stores = 0;
		model_mem = image;
		while (!model_halted && steps < MODEL_STEPS)
		begin
			ir = model_mem[pc[11:2]];
			pc = pc + 32'd4;
			steps++;
			op = ir[27:24];
			simm = {{16{ir[15]}}, ir[15:0]};
			addr = r[ir[19:16]] + simm;
			case (ir[31:28])
				4'h0: model_halted = (op != 4'h0);
				4'h3:
				begin
					a = r[ir[23:20]];
					b = r[ir[19:16]];
					cc = {a < b, $signed(a) < $signed(b), a == b};
				end
				4'h7:
				begin
					a = r[ir[19:16]];
					b = op[3] ? simm : r[ir[15:12]];
					case (op[2:0])
						3'd0: res = a + b;
						3'd1: res = a - b;
						3'd2: res = a & b;
						3'd3: res = a | b;
						3'd4: res = a ^ b;
						3'd5: res = a << b[4:0];
						3'd6: res = a >> b[4:0];
						default: model_halted = 1'b1;
					endcase
					if (!model_halted)
						r[ir[23:20]] = res;
				end
				4'h8: r[ir[23:20]] = {16'h0000, ir[15:0]};
				4'h9:
				begin
					w = model_mem[addr[11:2]];
					shift = 24 - 8 * int'(addr[1:0]);
					case (op[1:0])
						2'd1: r[ir[23:20]] = addr[1] ? {16'h0000, w[15:0]} : {16'h0000, w[31:16]};
						2'd2: r[ir[23:20]] = (w >> shift) & 32'h0000_00ff;
						default: r[ir[23:20]] = w;
					endcase
				end
				4'ha:
				begin
					w = r[ir[23:20]];
					st.cyc = 1'b1;
					st.stb = 1'b1;
					st.we = 1'b1;
					st.adr = addr[31:2];
					st.sel = lane_sel(op[1:0], addr[1:0]);
					case (op[1:0])
						2'd1: st.dat = {2{w[15:0]}};
						2'd2: st.dat = {4{w[7:0]}};
						default: st.dat = w;
					endcase
					mask = lane_mask(st.sel);
					model_mem[addr[11:2]] = (model_mem[addr[11:2]] & ~mask) | (st.dat & mask);
					exp_stores.push_back(st);
					model_stores++;
				end
				4'hb:
				begin
					if (branch_taken(op, cc))
						pc = pc + (simm << 2); // relative to the next insn
				end
				default: model_halted = 1'b1;
			endcase
		end
	endtask

	task automatic check_store(input wb_req_t got);
		wb_req_t exp;
		word_t mask;
		dut_stores++;
		if (exp_stores.size() == 0)
		begin
			$display("extra store from the DUT at word address %h", got.adr);
			other_errors++;
		end
		else
		begin
			exp = exp_stores.pop_front();
			mask = lane_mask(exp.sel);
			if (got.sel != exp.sel)
			begin
				$display("MISMATCH store_sel: expected %b actual %b", exp.sel, got.sel);
				mismatch_errors++;
			end
			if (got.adr != exp.adr)
			begin
				$display("MISMATCH store adr: expected %h actual %h", exp.adr, got.adr);
				mismatch_errors++;
			end
			if ((got.dat & mask) != (exp.dat & mask))
			begin
				$display("MISMATCH store data: expected %h actual %h", exp.dat & mask,
					got.dat & mask);
				mismatch_errors++;
			end
		end
	endtask

	initial
	begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	always @(posedge clk_i)
	begin
		if (wr_valid)
			check_store(wr_req);
	end

	initial
	begin
		rst_i = 1'b1;
		mismatch_errors = 0;
		other_errors = 0;
		dut_stores = 0;
		dropped = 1'b0;
		void'($urandom(SEED));
		build_program();
		run_model();
		repeat (5) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		cycles = 0;
		while (!halted && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge clk_i); // halted settles after the rising edge
			cycles++;
		end
		if (!halted)
		begin
			$display("timeout: DUT did not halt within %0d cycles", TIMEOUT_CYCLES);
			other_errors++;
		end
		else
		begin
			if (exp_stores.size() != 0)
			begin
				$display("DUT halted with %0d model stores still missing", exp_stores.size());
				other_errors++;
			end
			repeat (HOLD_CYCLES)
			begin
				@(negedge clk_i);
				if (!halted && !dropped)
				begin
					$display("halted dropped after the halt instruction");
					other_errors++;
					dropped = 1'b1;
				end
			end
		end
		if (dut_stores != model_stores)
		begin
			$display("store totals differ: DUT %0d, model %0d", dut_stores, model_stores);
			other_errors++;
		end
		$display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- flist.f
common/cpu_pkg.sv
control/cpu_control.sv
datapath/cpu_datapath.sv
verilog/fetch_port.sv
verilog/data_port.sv
verilog/bus_arbiter.sv
verilog/cpu_top.sv
verif/wb_mem.sv
verif/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --assert -j 0 -Wno-fatal
TOP ?= cpu_tb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FLIST)))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
